/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first pc fetched after reset, also the base of the instruction RAM
`define FETCH_RESET_PC 32'h8000_0000

// instruction RAM size in 32-bit words
`define IMEM_DEPTH 256

// cycles from address acceptance to read data, must be 1 or more
`define IMEM_LATENCY 2

// read channel response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

/* fetch_pkg.sv */
package fetch_pkg;

	`include "fetch_config.svh"

	// byte address on the read channel and for the pc
	typedef logic [31:0] addr_t;

	// one RV32I instruction word
	typedef logic [31:0] inst_t;

	// read channel response, see RESP_* codes
	typedef logic [1:0] resp_t;

	// word index into the instruction RAM
	typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_index_t;

	// fetch sequence
	// addr: address phase on the read channel
	// load: waiting for read data
	// deliver: one-cycle instruction strobe
	// hold: waiting for retire
	typedef enum logic [1:0] {
		FETCH_ADDR,
		FETCH_LOAD,
		FETCH_DELIVER,
		FETCH_HOLD
	} fetch_state_e;

endpackage

/* imem_read_if.sv */
`timescale 1ns/1ps

interface imem_read_if;

	// address phase
	fetch_pkg::addr_t addr;
	logic             addr_valid;
	logic             addr_ready;

	// data phase
	fetch_pkg::inst_t rdata;
	fetch_pkg::resp_t resp;
	logic             rvalid;
	logic             rready;

	modport master (
		output addr,
		output addr_valid,
		input  addr_ready,
		input  rdata,
		input  resp,
		input  rvalid,
		output rready
	);

	modport slave (
		input  addr,
		input  addr_valid,
		output addr_ready,
		output rdata,
		output resp,
		output rvalid,
		input  rready
	);

endinterface

/* pc_sequencer.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module pc_sequencer (
	input  logic             clock,
	input  logic             reset,
	input  logic             advance_i,
	input  logic             trap_redirect_i,
	input  fetch_pkg::addr_t trap_target_i,
	input  logic             jump_i,
	input  fetch_pkg::addr_t jump_target_i,
	input  logic             branch_request_i,
	input  logic             branch_taken_i,
	input  fetch_pkg::addr_t branch_target_i,
	output fetch_pkg::addr_t pc_o
);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t pc_next;
	fetch_pkg::addr_t pc_plus_4;

	assign pc_plus_4 = pc_q + 32'd4;

	// trap or return wins over jump, jump over a taken branch
	always_comb begin
		if (trap_redirect_i) begin
			pc_next = trap_target_i;
		end else if (jump_i) begin
			pc_next = jump_target_i;
		end else if (branch_request_i && branch_taken_i) begin
			pc_next = branch_target_i;
		end else begin
			pc_next = pc_plus_4;
		end
	end

	// only moves once the current instruction has retired
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= `FETCH_RESET_PC;
		end else if (advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

/* inst_legality_check.sv */
`timescale 1ns/1ps

module inst_legality_check (
	input  fetch_pkg::inst_t inst_i,
	output logic             illegal_o
);

	// major opcodes of the supported subset
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// full system encodings
	localparam fetch_pkg::inst_t INST_ECALL  = 32'h0000_0073;
	localparam fetch_pkg::inst_t INST_EBREAK = 32'h0010_0073;
	localparam fetch_pkg::inst_t INST_MRET   = 32'h3020_0073;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			OP_LUI, OP_AUIPC, OP_JAL, OP_BRANCH, OP_REG: legal = 1'b1;
			OP_JALR: legal = (funct3 == 3'b000);
			// lb lh lw lbu lhu
			OP_LOAD: legal = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
			// sb sh sw
			OP_STORE: legal = (funct3 inside {3'b000, 3'b001, 3'b010});
			OP_IMM: begin
				case (funct3)
					// slli
					3'b001: legal = (funct7 == 7'b0000000);
					// srli or srai
					3'b101: legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: legal = 1'b1;
				endcase
			end
			OP_SYSTEM: begin
				// csrrw csrrs, plus the three exact encodings
				legal = (funct3 == 3'b001) || (funct3 == 3'b010) ||
					(inst_i == INST_ECALL) || (inst_i == INST_EBREAK) ||
					(inst_i == INST_MRET);
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal_o = !legal;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit (
	input  logic               clock,
	input  logic               reset,
	input  logic               retire_i,
	input  logic               trap_redirect_i,
	input  fetch_pkg::addr_t   trap_target_i,
	input  logic               jump_i,
	input  fetch_pkg::addr_t   jump_target_i,
	input  logic               branch_request_i,
	input  logic               branch_taken_i,
	input  fetch_pkg::addr_t   branch_target_i,
	imem_read_if.master        imem,
	output fetch_pkg::inst_t   inst_o,
	output fetch_pkg::addr_t   pc_o,
	output logic               inst_valid_o,
	output logic               illegal_o,
	output logic               bus_error_o
);

	fetch_pkg::fetch_state_e state;
	fetch_pkg::fetch_state_e next_state;
	fetch_pkg::addr_t        pc;
	logic                    advance;
	logic                    addr_valid_q;
	logic                    addr_done;
	logic                    data_done;
	logic                    rdata_illegal;

	assign addr_done = imem.addr_valid && imem.addr_ready;
	assign data_done = imem.rvalid && imem.rready;

	// retire only counts while waiting for it
	assign advance = (state == fetch_pkg::FETCH_HOLD) && retire_i;

	always_comb begin
		next_state = state;
		case (state)
			fetch_pkg::FETCH_ADDR:    if (addr_done) next_state = fetch_pkg::FETCH_LOAD;
			fetch_pkg::FETCH_LOAD:    if (data_done) next_state = fetch_pkg::FETCH_DELIVER;
			fetch_pkg::FETCH_DELIVER: next_state = fetch_pkg::FETCH_HOLD;
			fetch_pkg::FETCH_HOLD:    if (retire_i) next_state = fetch_pkg::FETCH_ADDR;
			default:                  next_state = fetch_pkg::FETCH_ADDR;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::FETCH_ADDR;
		end else begin
			state <= next_state;
		end
	end

	// registered so it stays low through reset and rises with the reset pc
	always_ff @(posedge clock) begin
		if (reset) begin
			addr_valid_q <= 1'b0;
		end else begin
			addr_valid_q <= (next_state == fetch_pkg::FETCH_ADDR);
		end
	end

	// pc only changes in hold, so addr is stable during the address phase
	assign imem.addr       = pc;
	assign imem.addr_valid = addr_valid_q;
	assign imem.rready     = (state == fetch_pkg::FETCH_LOAD);

	pc_sequencer pc_sequencer_i (
		.clock            (clock),
		.reset            (reset),
		.advance_i        (advance),
		.trap_redirect_i  (trap_redirect_i),
		.trap_target_i    (trap_target_i),
		.jump_i           (jump_i),
		.jump_target_i    (jump_target_i),
		.branch_request_i (branch_request_i),
		.branch_taken_i   (branch_taken_i),
		.branch_target_i  (branch_target_i),
		.pc_o             (pc)
	);

	inst_legality_check inst_legality_check_i (
		.inst_i    (imem.rdata),
		.illegal_o (rdata_illegal)
	);

	// instruction and its pc kept until the next delivery
	always_ff @(posedge clock) begin
		if (data_done) begin
			inst_o <= imem.rdata;
			pc_o   <= pc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			illegal_o   <= 1'b0;
			bus_error_o <= 1'b0;
		end else if (data_done) begin
			illegal_o   <= rdata_illegal;
			bus_error_o <= (imem.resp != `RESP_OKAY);
		end
	end

	assign inst_valid_o = (state == fetch_pkg::FETCH_DELIVER);

endmodule

/* imem_slave.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module imem_slave (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load_en_i,
	input  fetch_pkg::imem_index_t load_index_i,
	input  fetch_pkg::inst_t       load_data_i,
	imem_read_if.slave             imem
);

	localparam int INDEX_W = $bits(fetch_pkg::imem_index_t);
	localparam int CNT_W   = $clog2(`IMEM_LATENCY + 1);

	fetch_pkg::inst_t mem [`IMEM_DEPTH];

	fetch_pkg::addr_t offset;
	logic             addr_ok;
	logic             busy;
	logic             rvalid_q;
	logic [CNT_W-1:0] count;
	fetch_pkg::inst_t rdata_q;
	fetch_pkg::resp_t resp_q;

	always_ff @(posedge clock) begin
		if (load_en_i) begin
			mem[load_index_i] <= load_data_i;
		end
	end

	// word aligned and inside the window above the reset pc
	assign offset  = imem.addr - `FETCH_RESET_PC;
	assign addr_ok = (imem.addr[1:0] == 2'b00) && (offset[31:2] < `IMEM_DEPTH);

	assign imem.addr_ready = !busy;

	// data sampled at acceptance, held until the data phase ends
	always_ff @(posedge clock) begin
		if (imem.addr_valid && !busy) begin
			rdata_q <= addr_ok ? mem[offset[INDEX_W+1:2]] : '0;
			resp_q  <= addr_ok ? `RESP_OKAY : `RESP_SLVERR;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy     <= 1'b0;
			rvalid_q <= 1'b0;
			count    <= '0;
		end else if (!busy) begin
			if (imem.addr_valid) begin
				busy  <= 1'b1;
				count <= CNT_W'(`IMEM_LATENCY - 1);
			end
		end else if (rvalid_q) begin
			// back-pressure holds the response
			if (imem.rready) begin
				busy     <= 1'b0;
				rvalid_q <= 1'b0;
			end
		end else if (count != '0) begin
			count <= count - 1'b1;
		end else begin
			rvalid_q <= 1'b1;
		end
	end

	assign imem.rvalid = rvalid_q;
	assign imem.rdata  = rdata_q;
	assign imem.resp   = resp_q;

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic                   clock,
	input  logic                   reset,
	// memory load
	input  logic                   load_en_i,
	input  fetch_pkg::imem_index_t load_index_i,
	input  fetch_pkg::inst_t       load_data_i,
	// redirects
	input  logic                   branch_request_i,
	input  logic                   branch_taken_i,
	input  fetch_pkg::addr_t       branch_target_i,
	input  logic                   jump_i,
	input  fetch_pkg::addr_t       jump_target_i,
	input  logic                   trap_redirect_i,
	input  fetch_pkg::addr_t       trap_target_i,
	input  logic                   retire_i,
	// results
	output fetch_pkg::inst_t       inst_o,
	output fetch_pkg::addr_t       pc_o,
	output logic                   inst_valid_o,
	output logic                   illegal_o,
	output logic                   bus_error_o
);

	imem_read_if imem_bus ();

	fetch_unit fetch_unit_i (
		.clock            (clock),
		.reset            (reset),
		.retire_i         (retire_i),
		.trap_redirect_i  (trap_redirect_i),
		.trap_target_i    (trap_target_i),
		.jump_i           (jump_i),
		.jump_target_i    (jump_target_i),
		.branch_request_i (branch_request_i),
		.branch_taken_i   (branch_taken_i),
		.branch_target_i  (branch_target_i),
		.imem             (imem_bus.master),
		.inst_o           (inst_o),
		.pc_o             (pc_o),
		.inst_valid_o     (inst_valid_o),
		.illegal_o        (illegal_o),
		.bus_error_o      (bus_error_o)
	);

	imem_slave imem_slave_i (
		.clock        (clock),
		.reset        (reset),
		.load_en_i    (load_en_i),
		.load_index_i (load_index_i),
		.load_data_i  (load_data_i),
		.imem         (imem_bus.slave)
	);

endmodule

/* fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
	input logic             clock,
	input logic             reset,
	input fetch_pkg::addr_t addr_i,
	input logic             addr_valid_i,
	input logic             rready_i,
	input logic             inst_valid_i
);

	// request address held into the cycle after it, taken or not
	addr_stable: assert property (@(posedge clock) disable iff (reset)
		addr_valid_i |=> $stable(addr_i))
		else $error("read address changed right after the address phase");

	// delivery strobe is a single-cycle pulse
	inst_valid_pulse: assert property (@(posedge clock) disable iff (reset)
		inst_valid_i |=> !inst_valid_i)
		else $error("inst_valid_o stayed high for more than one cycle");

	// address and data phases never overlap
	phases_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(addr_valid_i && rready_i))
		else $error("addr_valid and rready high in the same cycle");

endmodule

bind fetch_unit fetch_assertions fetch_assertions_i (
	.clock        (clock),
	.reset        (reset),
	.addr_i       (imem.addr),
	.addr_valid_i (imem.addr_valid),
	.rready_i     (imem.rready),
	.inst_valid_i (inst_valid_o)
);

/* fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;

	localparam int NUM_RANDOM      = 120;
	localparam int NUM_FETCHES     = NUM_RANDOM + 10;
	localparam int WATCHDOG_CYCLES = NUM_FETCHES * (`IMEM_LATENCY + 8) + `IMEM_DEPTH + 50;
	localparam fetch_pkg::addr_t BASE = `FETCH_RESET_PC;

	logic                   clock;
	logic                   reset;
	logic                   load_en_i;
	fetch_pkg::imem_index_t load_index_i;
	fetch_pkg::inst_t       load_data_i;
	logic                   branch_request_i;
	logic                   branch_taken_i;
	fetch_pkg::addr_t       branch_target_i;
	logic                   jump_i;
	fetch_pkg::addr_t       jump_target_i;
	logic                   trap_redirect_i;
	fetch_pkg::addr_t       trap_target_i;
	logic                   retire_i;
	fetch_pkg::inst_t       inst_o;
	fetch_pkg::addr_t       pc_o;
	logic                   inst_valid_o;
	logic                   illegal_o;
	logic                   bus_error_o;

	integer           seed = 32'h8aa6;
	int               cycle = 0;
	int               deliveries = 0;
	int               retire_cycle = -1;
	fetch_pkg::addr_t exp_pc = `FETCH_RESET_PC;
	fetch_pkg::inst_t model [`IMEM_DEPTH];

	fetch_top fetch_top_i (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	// flags are {trap, jump, branch request, branch taken}
	function automatic fetch_pkg::addr_t next_pc_ref(input fetch_pkg::addr_t pc,
			input logic [3:0] flags, input fetch_pkg::addr_t trap_tgt,
			input fetch_pkg::addr_t jump_tgt, input fetch_pkg::addr_t branch_tgt);
		if (flags[3]) return trap_tgt;
		if (flags[2]) return jump_tgt;
		if (flags[1] && flags[0]) return branch_tgt;
		return pc + 32'd4;
	endfunction

	function automatic logic illegal_ref(input fetch_pkg::inst_t w);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ok;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		ok = 1'b0;
		if (op == 7'h37 || op == 7'h17 || op == 7'h6f || op == 7'h63 || op == 7'h33)
			ok = 1'b1;
		else if (op == 7'h67)
			ok = (f3 == 3'd0);
		else if (op == 7'h03)
			ok = (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7);
		else if (op == 7'h23)
			ok = (f3 <= 3'd2);
		else if (op == 7'h13)
			ok = (f3 == 3'd1) ? (f7 == 7'h00) :
				(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
		else if (op == 7'h73)
			ok = (f3 == 3'd1 || f3 == 3'd2 || w == 32'h0000_0073 ||
				w == 32'h0010_0073 || w == 32'h3020_0073);
		return !ok;
	endfunction

	// system encodings at 1..3, then supported opcodes over random fields or raw noise
	function automatic fetch_pkg::inst_t make_word(input int index);
		logic [31:0] w;
		logic [31:0] r;
		w = $random(seed);
		r = $random(seed);
		if (index == 1) return 32'h0000_0073;
		if (index == 2) return 32'h0010_0073;
		if (index == 3) return 32'h3020_0073;
		case (r[3:0])
			4'd0: w[6:0] = 7'h37;
			4'd1: w[6:0] = 7'h17;
			4'd2: w[6:0] = 7'h6f;
			4'd3: w[6:0] = 7'h67;
			4'd4: w[6:0] = 7'h63;
			4'd5: w[6:0] = 7'h03;
			4'd6: w[6:0] = 7'h23;
			4'd7, 4'd8: begin
				// shift immediates, funct7 good or bad
				w[6:0] = 7'h13;
				w[13:12] = 2'b01;
				if (r[4]) w[31:25] = r[5] ? 7'h20 : 7'h00;
			end
			4'd9: w[6:0] = 7'h13;
			4'd10: w[6:0] = 7'h33;
			4'd11: w[6:0] = 7'h73;
			default: w = w;
		endcase
		return w;
	endfunction

	// mostly aligned words in range, some misaligned, some past the end
	function automatic fetch_pkg::addr_t pick_target();
		logic [31:0] r;
		r = $random(seed);
		if (r[31:29] == 3'd0) return BASE + 32'h400 + {22'b0, r[9:2], 2'b00};
		if (r[31:29] == 3'd1) return BASE + {22'b0, r[9:0]};
		return BASE + {22'b0, r[9:2], 2'b00};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_delivery();
		fetch_pkg::addr_t off;
		fetch_pkg::inst_t exp_inst;
		logic             exp_err;
		off = exp_pc - BASE;
		exp_err = !(exp_pc[1:0] == 2'b00 && off[31:2] < `IMEM_DEPTH);
		exp_inst = exp_err ? '0 : model[off[2 +: $clog2(`IMEM_DEPTH)]];
		compare_value($sformatf("fetch %0d pc", deliveries), exp_pc, pc_o);
		compare_value($sformatf("fetch %0d inst", deliveries), exp_inst, inst_o);
		compare_value($sformatf("fetch %0d illegal", deliveries),
			32'(illegal_ref(exp_inst)), 32'(illegal_o));
		compare_value($sformatf("fetch %0d bus_error", deliveries),
			32'(exp_err), 32'(bus_error_o));
		if (retire_cycle >= 0)
			compare_value($sformatf("fetch %0d latency", deliveries),
				32'(`IMEM_LATENCY + 3), 32'(cycle - retire_cycle));
	endtask

	always @(negedge clock) begin
		if (!reset && inst_valid_o) begin
			check_delivery();
			deliveries = deliveries + 1;
		end
	end

	task automatic retire_with_redirect(input logic [3:0] flags, input fetch_pkg::addr_t trap_tgt,
			input fetch_pkg::addr_t jump_tgt, input fetch_pkg::addr_t branch_tgt);
		int          count;
		logic [31:0] r;
		count = deliveries;
		{trap_redirect_i, jump_i, branch_request_i, branch_taken_i} = flags;
		trap_target_i = trap_tgt;
		jump_target_i = jump_tgt;
		branch_target_i = branch_tgt;
		exp_pc = next_pc_ref(exp_pc, flags, trap_tgt, jump_tgt, branch_tgt);
		retire_cycle = cycle;
		retire_i = 1'b1;
		// stray retires and redirect noise while the fetch is in flight
		repeat (3) begin
			@(negedge clock);
			r = $random(seed);
			retire_i = r[0];
			{trap_redirect_i, jump_i, branch_request_i, branch_taken_i} = r[4:1];
			trap_target_i = r;
		end
		@(negedge clock);
		retire_i = 1'b0;
		wait (deliveries == count + 1);
		@(negedge clock);
	endtask

	initial begin
		logic [31:0] r;
		reset = 1'b1;
		load_en_i = 1'b0;
		load_index_i = '0;
		load_data_i = '0;
		{trap_redirect_i, jump_i, branch_request_i, branch_taken_i, retire_i} = '0;
		trap_target_i = '0;
		jump_target_i = '0;
		branch_target_i = '0;
		// loading runs past the 2 reset cycles, nothing retires until it is done
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			model[i] = make_word(i);
			load_en_i = 1'b1;
			load_index_i = fetch_pkg::imem_index_t'(i);
			load_data_i = model[i];
			@(negedge clock);
			if (i == 1) reset = 1'b0;
		end
		load_en_i = 1'b0;
		wait (deliveries == 1);
		@(negedge clock);
		repeat (3) retire_with_redirect(4'b0000, '0, '0, '0);
		// misaligned, recover, past the end, trap over jump, wrap past the end, recover
		retire_with_redirect(4'b0100, '0, BASE + 32'd2, '0);
		retire_with_redirect(4'b0011, '0, '0, BASE + 32'h20);
		retire_with_redirect(4'b1000, BASE + 32'h400, '0, '0);
		retire_with_redirect(4'b1100, BASE + 32'h3fc, BASE, '0);
		retire_with_redirect(4'b0000, '0, '0, '0);
		retire_with_redirect(4'b0110, '0, BASE + 32'h40, BASE + 32'h80);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = $random(seed);
			retire_with_redirect({r[0] & r[1], r[2] & r[3], r[4], r[5]},
				pick_target(), pick_target(), pick_target());
		end
		$display("TEST OK");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: %0d of %0d fetches delivered after %0d cycles",
			deliveries, NUM_FETCHES, WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* tb.f */
+incdir+.
fetch_pkg.sv
imem_read_if.sv
pc_sequencer.sv
inst_legality_check.sv
fetch_unit.sv
imem_slave.sv
fetch_top.sv
fetch_assertions.sv
fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module fetch_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/Vfetch_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi
exit 0
